/* common/flash_pkg.sv */
//////////////////////////////
// NOR flash side of the boot ROM
// 16-bit devices, read access only, fixed access time per halfword
//////////////////////////////

package flash_pkg;

  // four banks, one device each
  localparam int NUM_BANKS = 4;
  localparam int BANK_BITS = 2;

  // halfword address lines on one device
  localparam int FLASH_ADR_BITS = 20;
  localparam int FLASH_DATA_BITS = 16;

  // access time of one halfword, in clock cycles
  localparam int WAIT_CYCLES = 6;
  // counter runs 1 .. WAIT_CYCLES
  localparam int WAIT_BITS = $clog2(WAIT_CYCLES + 1);

  typedef logic [FLASH_ADR_BITS-1:0] flash_adr_t;
  typedef logic [FLASH_DATA_BITS-1:0] flash_data_t;
  typedef logic [BANK_BITS-1:0] bank_sel_t;
  typedef logic [WAIT_BITS-1:0] wait_cnt_t;

endpackage

/* common/bus_pkg.sv */
//////////////////////////////
// Wishbone classic side, 32-bit data, word addressed
// byte lanes big-endian, sel[3] is byte offset 0
//////////////////////////////

package bus_pkg;

  // word address, top two bits pick the bank
  localparam int ADR_BITS = 21;
  localparam int WORD_BITS = 19;
  localparam int DATA_BITS = 32;
  localparam int SEL_BITS = 4;

  typedef logic [ADR_BITS-1:0] wb_adr_t;
  typedef logic [DATA_BITS-1:0] wb_data_t;
  typedef logic [SEL_BITS-1:0] wb_sel_t;

  // word within one bank
  typedef logic [WORD_BITS-1:0] bank_word_t;

  // byte offset inside the 32-bit word
  typedef logic [1:0] byte_ofs_t;

  // access width, 2'b11 has no meaning
  typedef logic [1:0] access_kind_t;

  localparam access_kind_t KIND_BYTE = 2'b00;
  localparam access_kind_t KIND_HALF = 2'b01;
  localparam access_kind_t KIND_WORD = 2'b10;

  // legal select patterns
  localparam wb_sel_t SEL_WORD = 4'b1111;
  localparam wb_sel_t SEL_HALF_HI = 4'b1100;
  localparam wb_sel_t SEL_HALF_LO = 4'b0011;

endpackage

/* design/bank_decoder.sv */
//////////////////////////////
// one bank request per bus cycle
// writes and odd sel patterns end with err and never reach a bank
//////////////////////////////

`timescale 1ns/100ps

module bank_decoder (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              cyc,
  input  logic                              stb,
  input  logic                              we,
  input  bus_pkg::wb_adr_t                  adr,
  input  bus_pkg::wb_sel_t                  sel,
  input  logic                              ack,
  output logic [flash_pkg::NUM_BANKS-1:0]   req,
  output bus_pkg::access_kind_t             kind,
  output bus_pkg::byte_ofs_t                byte_ofs,
  output bus_pkg::bank_word_t               flash_word,
  output logic                              err
);

  logic legal;
  logic pending;
  logic new_cycle;
  flash_pkg::bank_sel_t bank;

  // bank field above the word index
  assign bank = adr[bus_pkg::ADR_BITS-1:bus_pkg::WORD_BITS];
  assign flash_word = adr[bus_pkg::WORD_BITS-1:0];

  // classify sel on big-endian lanes
  always_comb begin
    legal = 1'b1;
    kind = bus_pkg::KIND_BYTE;
    byte_ofs = 2'd0;
    case (sel)
      bus_pkg::SEL_WORD: kind = bus_pkg::KIND_WORD;
      bus_pkg::SEL_HALF_HI: kind = bus_pkg::KIND_HALF;
      bus_pkg::SEL_HALF_LO: begin
        kind = bus_pkg::KIND_HALF;
        byte_ofs = 2'd2;
      end
      4'b1000: byte_ofs = 2'd0;
      4'b0100: byte_ofs = 2'd1;
      4'b0010: byte_ofs = 2'd2;
      4'b0001: byte_ofs = 2'd3;
      default: legal = 1'b0;
    endcase
  end

  // a cycle not yet answered
  assign new_cycle = cyc & stb & ~pending;

  // route to one bank only
  always_comb begin
    req = '0;
    if (new_cycle && !we && legal) begin
      req[bank] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= 1'b0;
      err <= 1'b0;
    end else begin
      // reject once on the first edge of the cycle
      err <= new_cycle & (we | ~legal);
      // held until the response has been seen
      if (ack || err) begin
        pending <= 1'b0;
      end else if (new_cycle) begin
        pending <= 1'b1;
      end
    end
  end

  a_req_onehot: assert property (@(posedge clk) disable iff (reset)
    $onehot0(req));

  // an ack only answers a cycle that was passed on to a bank
  a_ack_pending: assert property (@(posedge clk) disable iff (reset)
    ack |-> pending);

endmodule

/* flash_ctrl/flash_ctrl.sv */
//////////////////////////////
// one NOR bank, reads only
// word read is two halfwords, upper half first
//////////////////////////////

`timescale 1ns/100ps

module flash_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req,
  input  bus_pkg::access_kind_t  kind,
  input  bus_pkg::byte_ofs_t     byte_ofs,
  input  bus_pkg::bank_word_t    flash_word,
  input  flash_pkg::flash_data_t d,
  output logic                   done,
  output bus_pkg::wb_data_t      rdata,
  output logic                   ce_n,
  output logic                   oe_n,
  output flash_pkg::flash_adr_t  a
);

  typedef enum logic [1:0] {
    idle,
    wait_first,
    wait_second,
    finish
  } state_t;

  localparam flash_pkg::wait_cnt_t WAIT_LAST =
    flash_pkg::wait_cnt_t'(flash_pkg::WAIT_CYCLES);

  state_t state;
  flash_pkg::wait_cnt_t cnt;
  logic half_q;
  logic last_tick;
  bus_pkg::access_kind_t kind_q;
  bus_pkg::byte_ofs_t ofs_q;
  bus_pkg::bank_word_t word_q;

  // halfword address, a[0] picks the half
  assign a = {word_q, half_q};

  // access time of the current halfword has passed
  assign last_tick = (cnt == WAIT_LAST);

  // lane placement of the first halfword read
  function automatic bus_pkg::wb_data_t place_first(
    input bus_pkg::access_kind_t  k,
    input bus_pkg::byte_ofs_t     o,
    input flash_pkg::flash_data_t h
  );
    logic [15:0] hw;
    logic [7:0] b;
    bus_pkg::wb_data_t r;
    // low device byte sits at the lower address
    hw = {h[7:0], h[15:8]};
    b = o[0] ? h[15:8] : h[7:0];
    r = '0;
    case (k)
      bus_pkg::KIND_WORD: r[31:16] = hw;
      bus_pkg::KIND_HALF: begin
        if (o[1]) begin
          r[15:0] = hw;
        end else begin
          r[31:16] = hw;
        end
      end
      default: begin
        case (o)
          2'd0: r[31:24] = b;
          2'd1: r[23:16] = b;
          2'd2: r[15:8] = b;
          default: r[7:0] = b;
        endcase
      end
    endcase
    return r;
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      cnt <= '0;
      half_q <= 1'b0;
      done <= 1'b0;
      ce_n <= 1'b1;
      oe_n <= 1'b1;
    end else begin
      done <= 1'b0;
      case (state)
        idle: begin
          if (req) begin
            state <= wait_first;
            cnt <= flash_pkg::wait_cnt_t'(1);
            ce_n <= 1'b0;
            oe_n <= 1'b0;
            // word starts at the upper half
            half_q <= (kind == bus_pkg::KIND_WORD) ? 1'b0 : byte_ofs[1];
          end
        end
        wait_first: begin
          if (last_tick) begin
            cnt <= flash_pkg::wait_cnt_t'(1);
            if (kind_q == bus_pkg::KIND_WORD) begin
              state <= wait_second;
              half_q <= ~half_q;
            end else begin
              state <= finish;
              done <= 1'b1;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        wait_second: begin
          if (last_tick) begin
            state <= finish;
            done <= 1'b1;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          // release the device, back to idle
          state <= idle;
          ce_n <= 1'b1;
          oe_n <= 1'b1;
        end
      endcase
    end
  end

  // request fields and read data
  always_ff @(posedge clk) begin
    if (state == idle && req) begin
      kind_q <= kind;
      ofs_q <= byte_ofs;
      word_q <= flash_word;
    end
    if (state == wait_first && last_tick) begin
      rdata <= place_first(kind_q, ofs_q, d);
    end
    // lower half of a word read
    if (state == wait_second && last_tick) begin
      rdata[15:0] <= {d[7:0], d[15:8]};
    end
  end

  a_done_pulse: assert property (@(posedge clk) disable iff (reset)
    done |=> !done);

  a_ce_active: assert property (@(posedge clk) disable iff (reset)
    (state != idle) |-> (!ce_n && !oe_n));

endmodule

/* design/read_return.sv */
//////////////////////////////
// merges bank responses onto the bus
// dat_o is zero outside an ack cycle
//////////////////////////////

`timescale 1ns/100ps

module read_return (
  input  logic [flash_pkg::NUM_BANKS-1:0] done,
  input  bus_pkg::wb_data_t               rdata [flash_pkg::NUM_BANKS],
  input  logic                            dec_err,
  output logic                            ack,
  output logic                            err,
  output bus_pkg::wb_data_t               dat_o
);

  // any bank finishing acks the cycle
  assign ack = |done;
  assign err = dec_err;

  // and-or mux on the done pulses
  always_comb begin
    dat_o = '0;
    for (int i = 0; i < flash_pkg::NUM_BANKS; i++) begin
      if (done[i]) begin
        dat_o = dat_o | rdata[i];
      end
    end
  end

  // only the bank holding the cycle may finish
  always_comb begin
    a_done_onehot: assert ($onehot0(done));
  end

  // a rejected cycle never reaches a bank
  always_comb begin
    a_no_ack_err: assert (!(ack && dec_err));
  end

endmodule

/* design/flash_rom_sub.sv */
//////////////////////////////
// boot flash, Wishbone classic slave, read only
// no pipelining, dat_i is ignored, writes end with err
//////////////////////////////

`timescale 1ns/100ps

module flash_rom_sub (
  input  logic                            clk,
  input  logic                            reset,
  // Wishbone slave
  input  logic                            cyc,
  input  logic                            stb,
  input  logic                            we,
  input  bus_pkg::wb_adr_t                adr,
  input  bus_pkg::wb_sel_t                sel,
  input  bus_pkg::wb_data_t               dat_i,
  output logic                            ack,
  output logic                            err,
  output bus_pkg::wb_data_t               dat_o,
  // flash pins, one entry per bank
  output logic [flash_pkg::NUM_BANKS-1:0] ce_n,
  output logic [flash_pkg::NUM_BANKS-1:0] oe_n,
  output flash_pkg::flash_adr_t           a [flash_pkg::NUM_BANKS],
  input  flash_pkg::flash_data_t          d [flash_pkg::NUM_BANKS]
);

  logic [flash_pkg::NUM_BANKS-1:0] req;
  logic [flash_pkg::NUM_BANKS-1:0] done;
  bus_pkg::access_kind_t kind;
  bus_pkg::byte_ofs_t byte_ofs;
  bus_pkg::bank_word_t flash_word;
  bus_pkg::wb_data_t rdata [flash_pkg::NUM_BANKS];
  logic dec_err;

  // ack feeds back to clear the pending cycle
  bank_decoder u_decoder (
    .clk        (clk),
    .reset      (reset),
    .cyc        (cyc),
    .stb        (stb),
    .we         (we),
    .adr        (adr),
    .sel        (sel),
    .ack        (ack),
    .req        (req),
    .kind       (kind),
    .byte_ofs   (byte_ofs),
    .flash_word (flash_word),
    .err        (dec_err)
  );

  // kind, offset and word shared, req per bank
  for (genvar i = 0; i < flash_pkg::NUM_BANKS; i++) begin : g_bank
    flash_ctrl u_ctrl (
      .clk        (clk),
      .reset      (reset),
      .req        (req[i]),
      .kind       (kind),
      .byte_ofs   (byte_ofs),
      .flash_word (flash_word),
      .d          (d[i]),
      .done       (done[i]),
      .rdata      (rdata[i]),
      .ce_n       (ce_n[i]),
      .oe_n       (oe_n[i]),
      .a          (a[i])
    );
  end

  read_return u_return (
    .done    (done),
    .rdata   (rdata),
    .dec_err (dec_err),
    .ack     (ack),
    .err     (err),
    .dat_o   (dat_o)
  );

endmodule

/* tb/flash_model.sv */
//////////////////////////////
// behavioral NOR device, read only
// data bus floats high while not enabled
//////////////////////////////

`timescale 1ns/100ps

module flash_model #(
  parameter int BANK_ID = 0
) (
  input  logic                   ce_n,
  input  logic                   oe_n,
  input  flash_pkg::flash_adr_t  a,
  output flash_pkg::flash_data_t d
);

  flash_pkg::bank_sel_t bank_id;

  assign bank_id = flash_pkg::bank_sel_t'(BANK_ID);

  // content is bank index over the low 14 address bits, scrambled
  always_comb begin
    if (!ce_n && !oe_n) begin
      d = {bank_id, a[13:0]} ^ 16'hA5C3;
    end else begin
      d = '1;
    end
  end

endmodule

/* tb/tb_top.sv */
//////////////////////////////
// directed tests of the boot flash subsystem
// one bus cycle at a time with an idle cycle between them
//////////////////////////////

`timescale 1ns/100ps

module tb_top;

  localparam int TIMEOUT = 4 * flash_pkg::WAIT_CYCLES + 10;

  logic clk = 1'b0;
  logic reset;
  logic cyc;
  logic stb;
  logic we;
  bus_pkg::wb_adr_t adr;
  bus_pkg::wb_sel_t sel;
  bus_pkg::wb_data_t dat_i;
  logic ack;
  logic err;
  bus_pkg::wb_data_t dat_o;
  logic [flash_pkg::NUM_BANKS-1:0] ce_n;
  logic [flash_pkg::NUM_BANKS-1:0] oe_n;
  flash_pkg::flash_adr_t a [flash_pkg::NUM_BANKS];
  flash_pkg::flash_data_t d [flash_pkg::NUM_BANKS];

  int data_errs = 0;
  int lat_errs = 0;
  int resp_errs = 0;
  int addr_errs = 0;
  int other_errs = 0;
  logic [15:0] lfsr = 16'd40;

  always #5 clk = ~clk;

  flash_rom_sub dut0 (
    .clk   (clk),
    .reset (reset),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .sel   (sel),
    .dat_i (dat_i),
    .ack   (ack),
    .err   (err),
    .dat_o (dat_o),
    .ce_n  (ce_n),
    .oe_n  (oe_n),
    .a     (a),
    .d     (d)
  );

  // one device per bank
  for (genvar i = 0; i < flash_pkg::NUM_BANKS; i++) begin : g_flash
    flash_model #(.BANK_ID(i)) u_flash (
      .ce_n (ce_n[i]),
      .oe_n (oe_n[i]),
      .a    (a[i]),
      .d    (d[i])
    );
  end

  // 16-bit Galois LFSR shifting out of bit 0
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // device halfword at {word, half}
  function automatic flash_pkg::flash_data_t flash_half(
    input flash_pkg::bank_sel_t b,
    input bus_pkg::bank_word_t  w,
    input logic                 half
  );
    return {b, w[12:0], half} ^ 16'hA5C3;
  endfunction

  // lower-address byte of a halfword is bits 7:0 on big-endian lanes
  function automatic bus_pkg::wb_data_t expected_data(
    input flash_pkg::bank_sel_t b,
    input bus_pkg::bank_word_t  w,
    input bus_pkg::wb_sel_t     s
  );
    flash_pkg::flash_data_t hw0;
    flash_pkg::flash_data_t hw1;
    bus_pkg::wb_data_t full;
    bus_pkg::wb_data_t mask;
    hw0 = flash_half(b, w, 1'b0);
    hw1 = flash_half(b, w, 1'b1);
    full = {hw0[7:0], hw0[15:8], hw1[7:0], hw1[15:8]};
    for (int i = 0; i < 4; i++) begin
      mask[8*i +: 8] = {8{s[i]}};
    end
    return full & mask;
  endfunction

  task automatic check_data(input string name, input bus_pkg::wb_data_t expected,
                            input bus_pkg::wb_data_t actual);
    if (actual !== expected) begin
      data_errs++;
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_latency(input string name, input int expected, input int actual);
    if (actual != expected) begin
      lat_errs++;
      $display("ERROR %s: expected %0d cycles, actual %0d cycles", name, expected, actual);
    end
  endtask

  task automatic check_resp(input string name, input logic expect_err,
                            input logic got_ack, input logic got_err);
    if (got_ack !== !expect_err || got_err !== expect_err) begin
      resp_errs++;
      $display("ERROR %s: expected ack=%b err=%b, actual ack=%b err=%b",
               name, !expect_err, expect_err, got_ack, got_err);
    end
  endtask

  task automatic check_addr(input string name, input flash_pkg::flash_adr_t expected,
                            input flash_pkg::flash_adr_t actual);
    if (actual !== expected) begin
      addr_errs++;
      $display("ERROR %s: expected address %h, actual address %h", name, expected, actual);
    end
  endtask

  // one Wishbone cycle sampled 1 ns after each edge
  task automatic bus_cycle(
    input  logic                            wr,
    input  bus_pkg::wb_adr_t                addr,
    input  bus_pkg::wb_sel_t                s,
    output bus_pkg::wb_data_t               data,
    output int                              cycles,
    output logic                            got_ack,
    output logic                            got_err,
    output logic [flash_pkg::NUM_BANKS-1:0] ce_low
  );
    @(posedge clk);
    #1;
    cyc = 1'b1;
    stb = 1'b1;
    we = wr;
    adr = addr;
    sel = s;
    dat_i = wr ? 32'h1234_5678 : '0;
    cycles = 0;
    got_ack = 1'b0;
    got_err = 1'b0;
    ce_low = '0;
    data = '0;
    while (!got_ack && !got_err && cycles < TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
      ce_low = ce_low | ~ce_n;
      if (oe_n !== ce_n) begin
        other_errs++;
        $display("output enables %b do not follow chip enables %b", oe_n, ce_n);
      end
      if (ack || err) begin
        got_ack = ack;
        got_err = err;
        data = dat_o;
      end
    end
    // response lasts one cycle so the bus is released now
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    if (!got_ack && !got_err) begin
      other_errs++;
      $display("timeout: no ack or err within %0d cycles for address %h", TIMEOUT, addr);
    end
  endtask

  task automatic read_and_check(input string name, input flash_pkg::bank_sel_t b,
                                input bus_pkg::bank_word_t w, input bus_pkg::wb_sel_t s);
    bus_pkg::wb_data_t data;
    int cycles;
    int lat;
    logic got_ack;
    logic got_err;
    logic [flash_pkg::NUM_BANKS-1:0] ce_low;
    logic [flash_pkg::NUM_BANKS-1:0] ce_exp;
    flash_pkg::flash_adr_t a_exp;
    bus_cycle(1'b0, {b, w}, s, data, cycles, got_ack, got_err, ce_low);
    // word read is two device accesses
    lat = (s == 4'b1111) ? 2 * flash_pkg::WAIT_CYCLES + 1 : flash_pkg::WAIT_CYCLES + 1;
    ce_exp = 4'b0001 << b;
    // last halfword read is the lower one whenever the low lanes are selected
    a_exp = {w, |s[1:0]};
    check_resp(name, 1'b0, got_ack, got_err);
    check_latency(name, lat, cycles);
    check_data(name, expected_data(b, w, s), data);
    check_addr(name, a_exp, a[b]);
    if (ce_low !== ce_exp) begin
      other_errs++;
      $display("%s: chip enable went low on banks %b, only bank %0d should be active",
               name, ce_low, b);
    end
  endtask

  task automatic reject_and_check(input string name, input logic wr,
                                  input bus_pkg::wb_sel_t s);
    bus_pkg::wb_data_t data;
    int cycles;
    logic got_ack;
    logic got_err;
    logic [flash_pkg::NUM_BANKS-1:0] ce_low;
    bus_cycle(wr, 21'h0A_5A5A, s, data, cycles, got_ack, got_err, ce_low);
    check_resp(name, 1'b1, got_ack, got_err);
    check_latency(name, 1, cycles);
    if (ce_low !== '0) begin
      other_errs++;
      $display("%s: a rejected cycle enabled flash banks %b", name, ce_low);
    end
  endtask

  task automatic after_reset();
    if (ack !== 1'b0 || err !== 1'b0) begin
      other_errs++;
      $display("after reset: ack or err is not low (ack=%b err=%b)", ack, err);
    end
    if (ce_n !== '1 || oe_n !== '1) begin
      other_errs++;
      $display("after reset: flash enables are not all high (ce_n=%b oe_n=%b)", ce_n, oe_n);
    end
  endtask

  task automatic word_reads();
    bus_pkg::bank_word_t words [3];
    words[0] = 19'h0_0000;
    words[1] = 19'h7_FFFF;
    words[2] = 19'h1_2345;
    for (int i = 0; i < flash_pkg::NUM_BANKS; i++) begin
      for (int j = 0; j < 3; j++) begin
        read_and_check($sformatf("word b%0d w%05h", i, words[j]),
                       flash_pkg::bank_sel_t'(i), words[j], 4'b1111);
      end
    end
  endtask

  task automatic narrow_reads();
    flash_pkg::bank_sel_t bs;
    bus_pkg::bank_word_t w;
    for (int i = 0; i < flash_pkg::NUM_BANKS; i++) begin
      bs = flash_pkg::bank_sel_t'(i);
      w = 19'h2_A5A0 ^ {17'd0, bs};
      read_and_check($sformatf("half hi b%0d", i), bs, w, 4'b1100);
      read_and_check($sformatf("half lo b%0d", i), bs, w, 4'b0011);
      // byte offset 0 is sel bit 3
      for (int o = 0; o < 4; o++) begin
        read_and_check($sformatf("byte b%0d ofs%0d", i, o), bs, w, 4'b1000 >> o);
      end
    end
  endtask

  task automatic rejected_cycles();
    reject_and_check("write word", 1'b1, 4'b1111);
    reject_and_check("write byte", 1'b1, 4'b0001);
    reject_and_check("sel 0000", 1'b0, 4'b0000);
    reject_and_check("sel 0110", 1'b0, 4'b0110);
    reject_and_check("sel 1010", 1'b0, 4'b1010);
    reject_and_check("sel 0111", 1'b0, 4'b0111);
    reject_and_check("sel 1110", 1'b0, 4'b1110);
  endtask

  task automatic random_reads();
    logic [31:0] v;
    flash_pkg::bank_sel_t b;
    bus_pkg::bank_word_t w;
    bus_pkg::wb_sel_t s;
    logic [1:0] k;
    logic [1:0] ofs;
    for (int i = 0; i < 40; i++) begin
      take_bits(2, v);
      b = v[1:0];
      take_bits(19, v);
      w = v[18:0];
      take_bits(2, v);
      k = v[1:0];
      take_bits(2, v);
      ofs = v[1:0];
      // kind code 3 falls back to a word read
      case (k)
        2'd0: s = 4'b1000 >> ofs;
        2'd1: s = ofs[1] ? 4'b0011 : 4'b1100;
        default: s = 4'b1111;
      endcase
      read_and_check($sformatf("random %0d sel %b", i, s), b, w, s);
    end
  endtask

  initial begin
    reset = 1'b1;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    sel = '0;
    dat_i = '0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    after_reset();
    word_reads();
    narrow_reads();
    rejected_cycles();
    random_reads();
    repeat (2) @(posedge clk);
    $display("errors: data %0d, latency %0d, response %0d, address %0d, other %0d",
             data_errs, lat_errs, resp_errs, addr_errs, other_errs);
    if (data_errs + lat_errs + resp_errs + addr_errs + other_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* flash_rom.f */
common/flash_pkg.sv
common/bus_pkg.sv
design/bank_decoder.sv
flash_ctrl/flash_ctrl.sv
design/read_return.sv
design/flash_rom_sub.sv
tb/flash_model.sv
tb/tb_top.sv

/* Makefile */
# Verilator build of the boot flash testbench

VERILATOR ?= verilator
TOP       ?= tb_top
RTL_TOP   ?= flash_rom_sub
FILELIST  ?= flash_rom.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
LINTFLAGS ?= --lint-only --timing --timescale 1ns/100ps
PASS_MSG  ?= RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the pass line in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
